//--- Makefile
TOOL      := verilator
TOP       := tb_debug_unit
FILELIST  := all.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
source/debug_pkg.sv
source/dump_pkg.sv
source/command_sequencer.sv
source/word_dump_channel.sv
source/tx_credit_mux.sv
source/debug_unit.sv
tests/tb_debug_unit.sv

//--- source/command_sequencer.sv
`timescale 1ns/1ps

module command_sequencer (
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  logic                            i_rx_done,
    input  debug_pkg::byte_t                i_rx_data,
    input  logic                            i_halt,
    input  logic [dump_pkg::N_CHANNELS-1:0] i_dump_done,
    output logic [dump_pkg::N_CHANNELS-1:0] o_dump_start,
    output debug_pkg::im_write_t            o_im_write,
    output logic                            o_run_enable,
    output logic                            o_step_mode,
    output logic                            o_step,
    output logic                            o_dump_dm
);
    import debug_pkg::*;
    import dump_pkg::*;

    seq_state_e state;
    im_addr_t   load_addr;       // Next program byte address
    ch_idx_t    dump_ch;         // Channel currently streaming
    ch_idx_t    next_ch;
    logic       dump_from_step;  // Chain PC, DM, RB and go back to step mode
    cmd_e       cmd;

    assign cmd     = cmd_e'(i_rx_data);
    assign next_ch = dump_ch + 1'b1;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state          <= ST_IDLE;
            load_addr      <= '0;
            dump_ch        <= CH_PC;
            dump_from_step <= 1'b0;
            o_dump_start   <= '0;
            o_im_write     <= '0;
            o_run_enable   <= 1'b0;
            o_step_mode    <= 1'b0;
            o_step         <= 1'b0;
            o_dump_dm      <= 1'b0;
        end else begin
            // Pulses last one cycle
            o_dump_start      <= '0;
            o_im_write.enable <= 1'b0;
            o_step            <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (i_rx_done) begin
                        dump_from_step <= 1'b0;
                        case (cmd)
                            CMD_WRITE_PROGRAM: begin
                                state     <= ST_LOAD;
                                load_addr <= '0;
                            end
                            CMD_SEND_PC: begin
                                state                <= ST_DUMP;
                                dump_ch              <= CH_PC;
                                o_dump_start[CH_PC]  <= 1'b1;
                            end
                            CMD_SEND_DM: begin
                                state                <= ST_DUMP;
                                dump_ch              <= CH_DM;
                                o_dump_start[CH_DM]  <= 1'b1;
                                o_dump_dm            <= 1'b1;  // Memory address from us
                            end
                            CMD_SEND_RB: begin
                                state                <= ST_DUMP;
                                dump_ch              <= CH_RB;
                                o_dump_start[CH_RB]  <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end

                ST_LOAD: begin
                    if (i_rx_done) begin
                        o_im_write <= '{enable: 1'b1, address: load_addr, data: i_rx_data};
                        load_addr  <= load_addr + 1'b1;
                        if (load_addr == im_addr_t'(IM_DEPTH - 1)) begin
                            state <= ST_READY;
                        end
                    end
                end

                ST_READY: begin
                    if (i_rx_done && cmd == CMD_START) begin
                        state        <= ST_RUN;
                        o_run_enable <= 1'b1;
                    end else if (i_rx_done && cmd == CMD_STEP_MODE) begin
                        state        <= ST_STEP_MODE;
                        o_run_enable <= 1'b1;
                        o_step_mode  <= 1'b1;
                    end
                end

                ST_RUN: begin
                    if (i_halt) begin
                        state        <= ST_IDLE;
                        o_run_enable <= 1'b0;
                    end
                end

                ST_STEP_MODE: begin
                    if (i_halt) begin
                        state        <= ST_IDLE;
                        o_run_enable <= 1'b0;
                        o_step_mode  <= 1'b0;
                    end else if (o_step) begin
                        // Step has been issued, freeze and dump
                        state               <= ST_DUMP;
                        o_run_enable        <= 1'b0;
                        dump_from_step      <= 1'b1;
                        dump_ch             <= CH_PC;
                        o_dump_start[CH_PC] <= 1'b1;
                    end else if (i_rx_done && cmd == CMD_STEP) begin
                        o_step <= 1'b1;
                    end else if (i_rx_done && cmd == CMD_CONTINUE) begin
                        state       <= ST_RUN;
                        o_step_mode <= 1'b0;
                    end
                end

                ST_DUMP: begin
                    if (i_dump_done[dump_ch]) begin
                        o_dump_dm <= 1'b0;
                        if (dump_from_step && dump_ch != CH_RB) begin
                            dump_ch               <= next_ch;
                            o_dump_start[next_ch] <= 1'b1;
                            o_dump_dm             <= (next_ch == CH_DM);
                        end else if (dump_from_step) begin
                            state        <= ST_STEP_MODE;
                            o_run_enable <= 1'b1;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- source/debug_pkg.sv
package debug_pkg;

    // One byte on the UART link
    typedef logic [7:0] byte_t;

    // Host command codes as sent over the UART
    typedef enum logic [7:0] {
        CMD_WRITE_PROGRAM = 8'd1,
        CMD_START         = 8'd2,
        CMD_STEP_MODE     = 8'd3,
        CMD_SEND_RB       = 8'd4,  // Register bank dump
        CMD_SEND_DM       = 8'd5,  // Data memory dump
        CMD_SEND_PC       = 8'd6,
        CMD_STEP          = 8'd7,
        CMD_CONTINUE      = 8'd8   // Leave step mode, run freely
    } cmd_e;

    // Program size in bytes for one load
    localparam int IM_DEPTH = 256;

    typedef logic [7:0] im_addr_t;

    // Write port toward the instruction memory
    typedef struct packed {
        logic     enable;
        im_addr_t address;
        byte_t    data;
    } im_write_t;

    // Sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,       // Taking program bytes
        ST_READY,      // Program loaded, waiting for start
        ST_RUN,
        ST_STEP_MODE,
        ST_DUMP        // One channel streaming to the UART
    } seq_state_e;

endpackage

//--- source/debug_unit.sv
`timescale 1ns/1ps

module debug_unit (
    input  logic                 i_clock,
    input  logic                 i_reset,

    // UART receiver
    input  logic                 i_rx_done,
    input  debug_pkg::byte_t     i_rx_data,

    // UART transmitter
    output logic                 o_tx_start,
    output debug_pkg::byte_t     o_tx_data,
    input  logic                 i_tx_done,

    // Datapath control
    input  logic                 i_halt,
    output logic                 o_run_enable,
    output logic                 o_step_mode,
    output logic                 o_step,

    // Memory side
    output debug_pkg::im_write_t o_im_write,
    output dump_pkg::dump_addr_t o_dm_addr,
    output dump_pkg::dump_addr_t o_rb_addr,
    output logic                 o_dump_dm,
    input  dump_pkg::word_t      i_pc_value,
    input  dump_pkg::word_t      i_dm_data,
    input  dump_pkg::word_t      i_rb_data
);
    import dump_pkg::*;

    logic [N_CHANNELS-1:0] dump_start;
    logic [N_CHANNELS-1:0] dump_done;
    logic [N_CHANNELS-1:0] accept;
    byte_offer_t           ch_offer [N_CHANNELS];
    dump_addr_t            ch_addr  [N_CHANNELS];
    word_t                 ch_word  [N_CHANNELS];

    // Word source behind each channel
    assign ch_word[CH_PC] = i_pc_value;
    assign ch_word[CH_DM] = i_dm_data;
    assign ch_word[CH_RB] = i_rb_data;

    assign o_dm_addr = ch_addr[CH_DM];
    assign o_rb_addr = ch_addr[CH_RB];  // PC channel address goes nowhere

    command_sequencer u_sequencer (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_rx_done    (i_rx_done),
        .i_rx_data    (i_rx_data),
        .i_halt       (i_halt),
        .i_dump_done  (dump_done),
        .o_dump_start (dump_start),
        .o_im_write   (o_im_write),
        .o_run_enable (o_run_enable),
        .o_step_mode  (o_step_mode),
        .o_step       (o_step),
        .o_dump_dm    (o_dump_dm)
    );

    for (genvar ch = 0; ch < N_CHANNELS; ch++) begin : g_channel
        word_dump_channel #(
            .DEPTH (CHANNEL_DEPTH[ch])
        ) u_channel (
            .i_clock  (i_clock),
            .i_reset  (i_reset),
            .i_start  (dump_start[ch]),
            .i_word   (ch_word[ch]),
            .i_accept (accept[ch]),
            .o_addr   (ch_addr[ch]),
            .o_offer  (ch_offer[ch]),
            .o_done   (dump_done[ch])
        );
    end

    tx_credit_mux u_tx_mux (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_offers   (ch_offer),
        .i_tx_done  (i_tx_done),
        .o_accept   (accept),
        .o_tx_start (o_tx_start),
        .o_tx_data  (o_tx_data)
    );

endmodule

//--- source/dump_pkg.sv
package dump_pkg;

    // Datapath word and dump addressing
    typedef logic [31:0] word_t;
    typedef logic [4:0]  dump_addr_t;

    // Byte position inside a word, 0 is the MSB
    typedef logic [1:0] byte_sel_t;

    // Dump channels, in the order a step dump walks them
    localparam int N_CHANNELS = 3;
    typedef logic [$clog2(N_CHANNELS)-1:0] ch_idx_t;

    localparam ch_idx_t CH_PC = ch_idx_t'(0);
    localparam ch_idx_t CH_DM = ch_idx_t'(1);
    localparam ch_idx_t CH_RB = ch_idx_t'(2);

    // Words per channel: PC, DM, RB
    localparam int CHANNEL_DEPTH [N_CHANNELS] = '{1, 32, 32};

    // One byte offered by a channel to the transmit side
    typedef struct packed {
        logic             valid;
        debug_pkg::byte_t data;
    } byte_offer_t;

    // Transmitter buffering, in bytes
    localparam int TX_CREDITS = 1;
    localparam int CREDIT_W   = $clog2(TX_CREDITS + 1);
    typedef logic [CREDIT_W-1:0] credit_t;

endpackage

//--- source/tx_credit_mux.sv
`timescale 1ns/1ps

module tx_credit_mux (
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  dump_pkg::byte_offer_t           i_offers [dump_pkg::N_CHANNELS],
    input  logic                            i_tx_done,
    output logic [dump_pkg::N_CHANNELS-1:0] o_accept,
    output logic                            o_tx_start,
    output debug_pkg::byte_t                o_tx_data
);
    import debug_pkg::*;
    import dump_pkg::*;

    credit_t credits;     // Free slots in the transmitter
    logic    pick_valid;
    ch_idx_t pick_ch;
    byte_t   pick_data;
    logic    issue;

    // Lowest index wins, only one channel is active at a time anyway
    always_comb begin
        pick_valid = 1'b0;
        pick_ch    = '0;
        for (int ch = N_CHANNELS - 1; ch >= 0; ch--) begin
            if (i_offers[ch].valid) begin
                pick_valid = 1'b1;
                pick_ch    = ch_idx_t'(ch);
            end
        end
    end

    assign pick_data = i_offers[pick_ch].data;
    assign issue     = pick_valid && (credits != '0);

    always_comb begin
        o_accept          = '0;
        o_accept[pick_ch] = issue;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            credits    <= credit_t'(TX_CREDITS);
            o_tx_start <= 1'b0;
            o_tx_data  <= '0;
        end else begin
            o_tx_start <= issue;
            if (issue) begin
                o_tx_data <= pick_data;
            end
            // Spend on issue, get back on tx done
            case ({issue, i_tx_done})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- source/word_dump_channel.sv
`timescale 1ns/1ps

module word_dump_channel #(
    parameter int DEPTH = 1  // Words to dump, 1 to 32
) (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_start,
    input  dump_pkg::word_t      i_word,
    input  logic                 i_accept,
    output dump_pkg::dump_addr_t o_addr,
    output dump_pkg::byte_offer_t o_offer,
    output logic                 o_done
);
    import dump_pkg::*;

    logic       busy;
    dump_addr_t addr;
    byte_sel_t  byte_sel;
    logic       last_byte;

    assign last_byte = (byte_sel == 2'd3) && (addr == dump_addr_t'(DEPTH - 1));
    assign o_addr    = addr;

    // Byte 0 is bits 31:24
    always_comb begin
        o_offer.valid = busy;
        o_offer.data  = busy ? i_word[8 * (3 - byte_sel) +: 8] : '0;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            busy     <= 1'b0;
            addr     <= '0;
            byte_sel <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start && !busy) begin
                busy     <= 1'b1;
                addr     <= '0;
                byte_sel <= '0;
            end else if (busy && i_accept) begin
                byte_sel <= byte_sel + 1'b1;  // Wraps after byte 3
                if (byte_sel == 2'd3) begin
                    addr <= addr + 1'b1;
                end
                if (last_byte) begin
                    busy   <= 1'b0;
                    addr   <= '0;
                    o_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- tests/tb_debug_unit.sv
`timescale 1ns/1ps

module tb_debug_unit;
    import debug_pkg::*;
    import dump_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int MEM_WORDS   = 32;
    localparam int N_STEPS     = 3;
    localparam int FAST_TX_MAX = 6;
    localparam int SLOW_TX_MIN = 10;
    localparam int SLOW_TX_MAX = 40;
    localparam int LOAD_CYCLES = 2 * 2 * (IM_DEPTH + 4);  // Two loads at two cycles a byte
    localparam int DUMP_BYTES  = 4 * (1 + 2 * MEM_WORDS);
    localparam int WATCHDOG_CYCLES = LOAD_CYCLES + (1 + N_STEPS) * DUMP_BYTES * (FAST_TX_MAX + 4)
                                   + DUMP_BYTES * (SLOW_TX_MAX + 4) + 2000;

    logic       i_clock   = 1'b0;
    logic       i_reset   = 1'b1;
    logic       i_rx_done = 1'b0;
    byte_t      i_rx_data = '0;
    logic       i_tx_done = 1'b0;
    logic       i_halt    = 1'b0;
    logic       o_tx_start;
    byte_t      o_tx_data;
    logic       o_run_enable;
    logic       o_step_mode;
    logic       o_step;
    im_write_t  o_im_write;
    dump_addr_t o_dm_addr;
    dump_addr_t o_rb_addr;
    logic       o_dump_dm;
    word_t      i_pc_value;
    word_t      i_dm_data;
    word_t      i_rb_data;

    // Datapath and memory models
    word_t      pc_reg;
    word_t      dm_mem [MEM_WORDS];
    word_t      rb_mem [MEM_WORDS];
    byte_t      prog [IM_DEPTH];
    byte_t      im_capture [IM_DEPTH];

    logic [8:0] expect_q [$];  // {o_dump_dm, byte}
    int         tx_wait;
    int         tx_min;
    int         tx_max;
    int         outstanding;
    int         writes_seen;
    int         bytes_seen;
    int         step_count;
    int         errors;
    int         test_errors;
    int         tests_run;
    string      test_name = "reset";

    assign i_pc_value = pc_reg;
    assign i_dm_data  = dm_mem[o_dm_addr];
    assign i_rb_data  = rb_mem[o_rb_addr];

    debug_unit DUT (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_rx_done    (i_rx_done),
        .i_rx_data    (i_rx_data),
        .o_tx_start   (o_tx_start),
        .o_tx_data    (o_tx_data),
        .i_tx_done    (i_tx_done),
        .i_halt       (i_halt),
        .o_run_enable (o_run_enable),
        .o_step_mode  (o_step_mode),
        .o_step       (o_step),
        .o_im_write   (o_im_write),
        .o_dm_addr    (o_dm_addr),
        .o_rb_addr    (o_rb_addr),
        .o_dump_dm    (o_dump_dm),
        .i_pc_value   (i_pc_value),
        .i_dm_data    (i_dm_data),
        .i_rb_data    (i_rb_data)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    // UART transmitter with a random done delay
    always @(posedge i_clock) begin
        if (i_reset) begin
            tx_wait   <= 0;
            i_tx_done <= 1'b0;
        end else if (o_tx_start) begin
            tx_wait   <= $urandom_range(tx_max, tx_min);
            i_tx_done <= 1'b0;
        end else if (tx_wait == 1) begin
            tx_wait   <= 0;
            i_tx_done <= 1'b1;
        end else begin
            i_tx_done <= 1'b0;
            if (tx_wait > 1) begin
                tx_wait <= tx_wait - 1;
            end
        end
    end

    always @(posedge i_clock) begin
        if (i_reset) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(o_tx_start) - int'(i_tx_done);
        end
    end

    // Byte stream against the expected queue
    always @(posedge i_clock) begin : check_bytes
        logic [8:0] want;
        if (!i_reset && o_tx_start) begin
            bytes_seen++;
            if (expect_q.size() == 0) begin
                report_failure("the DUT sent a byte when none was expected");
            end else begin
                want = expect_q.pop_front();
                assert (o_tx_data == want[7:0])
                    else report_mismatch("tx byte", 32'(want[7:0]), 32'(o_tx_data));
                assert (o_dump_dm == want[8])
                    else report_mismatch("o_dump_dm", 32'(want[8]), 32'(o_dump_dm));
            end
        end
    end

    always @(posedge i_clock) begin
        if (!i_reset && o_im_write.enable) begin
            assert (o_im_write.address == im_addr_t'(writes_seen))
                else report_mismatch("im address", 32'(writes_seen), 32'(o_im_write.address));
            im_capture[o_im_write.address] <= o_im_write.data;
            writes_seen++;
        end
        if (!i_reset && o_step) begin
            step_count++;
        end
    end

    a_credit: assert property (@(posedge i_clock) disable iff (i_reset)
        o_tx_start |-> outstanding < TX_CREDITS)
        else report_failure("a byte was sent while the transmitter had no free slot");
    a_step_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
        o_step |=> !o_step)
        else report_failure("o_step stayed high for more than one cycle");
    a_frozen_dump: assert property (@(posedge i_clock) disable iff (i_reset)
        o_tx_start |-> !o_run_enable)
        else report_failure("o_run_enable was high while a dump was sending");
    a_reset_low: assert property (@(posedge i_clock)
        $fell(i_reset) |-> !o_tx_start && o_tx_data == '0 && !o_run_enable && !o_step_mode
            && !o_step && o_im_write == '0 && o_dm_addr == '0 && o_rb_addr == '0 && !o_dump_dm)
        else report_failure("outputs were not low after reset");

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        test_errors++;
        $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        test_errors++;
        $display("%s failed: %s", test_name, what);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %-16s %s, %0d failed checks", test_name,
                 test_errors == 0 ? "ok" : "FAILED", test_errors);
    endtask

    task automatic send_byte(input byte_t b);
        @(posedge i_clock);
        i_rx_done <= 1'b1;
        i_rx_data <= b;
        @(posedge i_clock);
        i_rx_done <= 1'b0;
    endtask

    task automatic wait_state(input seq_state_e want, input int limit);
        int n;
        n = 0;
        while (DUT.u_sequencer.state != want && n < limit) begin
            @(negedge i_clock);
            n++;
        end
        if (DUT.u_sequencer.state != want) begin
            report_failure($sformatf("sequencer stayed in %s instead of reaching %s",
                                     DUT.u_sequencer.state.name(), want.name()));
        end
    endtask

    task automatic wait_drained(input int n_bytes);
        int n;
        n = 0;
        while (expect_q.size() != 0 && n < n_bytes * (tx_max + 4) + 20) begin
            @(negedge i_clock);
            n++;
        end
        if (expect_q.size() != 0) begin
            report_failure($sformatf("%0d expected bytes never arrived", expect_q.size()));
            expect_q.delete();
        end
    endtask

    // Four bytes per word in MSB-first order
    task automatic expect_word(input word_t w, input logic dm_flag);
        for (int b = 0; b < 4; b++) begin
            expect_q.push_back({dm_flag, w[31 - 8 * b -: 8]});
        end
    endtask

    task automatic expect_channel(input cmd_e cmd);
        case (cmd)
            CMD_SEND_PC: expect_word(pc_reg, 1'b0);
            CMD_SEND_DM: for (int a = 0; a < MEM_WORDS; a++) expect_word(dm_mem[a], 1'b1);
            default:     for (int a = 0; a < MEM_WORDS; a++) expect_word(rb_mem[a], 1'b0);
        endcase
    endtask

    task automatic load_program();
        int n;
        writes_seen = 0;
        for (int i = 0; i < IM_DEPTH; i++) begin
            prog[i] = byte_t'($urandom);
        end
        send_byte(CMD_WRITE_PROGRAM);
        for (int i = 0; i < IM_DEPTH; i++) begin
            send_byte(prog[i]);
        end
        // Last write pulse lands a cycle after its byte
        n = 0;
        while (writes_seen < IM_DEPTH && n < 20) begin
            @(negedge i_clock);
            n++;
        end
        wait_state(ST_READY, 20);
        assert (writes_seen == IM_DEPTH)
            else report_mismatch("write pulses", 32'(IM_DEPTH), 32'(writes_seen));
        for (int i = 0; i < IM_DEPTH; i++) begin
            assert (im_capture[i] == prog[i])
                else report_mismatch($sformatf("im byte %0d", i), 32'(prog[i]),
                                     32'(im_capture[i]));
        end
    endtask

    task automatic dump_alone(input cmd_e cmd, input int n_bytes);
        bytes_seen = 0;
        expect_channel(cmd);
        send_byte(cmd);
        wait_drained(n_bytes);
        wait_state(ST_IDLE, 20);
        assert (bytes_seen == n_bytes)
            else report_mismatch($sformatf("bytes for %s", cmd.name()), 32'(n_bytes),
                                 32'(bytes_seen));
    endtask

    task automatic halt_datapath();
        @(posedge i_clock);
        i_halt <= 1'b1;
        @(negedge i_clock);
        assert (o_run_enable) else report_failure("o_run_enable dropped before i_halt");
        @(posedge i_clock);
        i_halt <= 1'b0;
        @(negedge i_clock);
        assert (!o_run_enable) else report_failure("o_run_enable still high after i_halt");
    endtask

    initial begin
        void'($urandom(32'h59e880ba));
        tx_min = 1;
        tx_max = FAST_TX_MAX;
        pc_reg = word_t'($urandom);
        for (int a = 0; a < MEM_WORDS; a++) begin
            dm_mem[a] = word_t'($urandom);
            rb_mem[a] = word_t'($urandom);
        end
        repeat (8) @(posedge i_clock);
        i_reset <= 1'b0;

        begin_test("program_load");
        load_program();
        send_byte(CMD_START);
        wait_state(ST_RUN, 20);
        @(negedge i_clock);
        assert (o_run_enable && !o_step_mode) else report_failure("start did not begin a run");
        assert (writes_seen == IM_DEPTH)
            else report_mismatch("writes after start", 32'(IM_DEPTH), 32'(writes_seen));
        end_test();

        begin_test("run_halt");
        repeat ($urandom_range(30, 5)) begin
            @(negedge i_clock);
            assert (o_run_enable) else report_failure("o_run_enable dropped during the run");
        end
        halt_datapath();
        wait_state(ST_IDLE, 20);
        end_test();

        begin_test("standalone_dumps");
        dump_alone(CMD_SEND_PC, 4);
        dump_alone(CMD_SEND_DM, 4 * MEM_WORDS);
        dump_alone(CMD_SEND_RB, 4 * MEM_WORDS);
        end_test();

        begin_test("step");
        load_program();
        send_byte(CMD_STEP_MODE);
        wait_state(ST_STEP_MODE, 20);
        for (int s = 0; s < N_STEPS; s++) begin
            @(posedge i_clock);
            pc_reg <= pc_reg + 32'd4;  // Datapath moved on
            @(negedge i_clock);
            assert (o_run_enable && o_step_mode) else report_failure("not running in step mode");
            step_count = 0;
            bytes_seen = 0;
            expect_channel(CMD_SEND_PC);
            expect_channel(CMD_SEND_DM);
            expect_channel(CMD_SEND_RB);
            send_byte(CMD_STEP);
            wait_drained(DUMP_BYTES);
            wait_state(ST_STEP_MODE, 20);
            assert (step_count == 1) else report_mismatch("o_step pulses", 32'd1, 32'(step_count));
            assert (bytes_seen == DUMP_BYTES)
                else report_mismatch("step dump bytes", 32'(DUMP_BYTES), 32'(bytes_seen));
        end
        send_byte(CMD_CONTINUE);
        wait_state(ST_RUN, 20);
        @(negedge i_clock);
        assert (o_run_enable && !o_step_mode)
            else report_failure("continue did not resume the run");
        halt_datapath();
        wait_state(ST_IDLE, 20);
        end_test();

        begin_test("back_pressure");
        tx_min = SLOW_TX_MIN;
        tx_max = SLOW_TX_MAX;
        dump_alone(CMD_SEND_PC, 4);
        dump_alone(CMD_SEND_DM, 4 * MEM_WORDS);
        dump_alone(CMD_SEND_RB, 4 * MEM_WORDS);
        end_test();

        $display("Tests run: %0d, failed checks: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Bound from the byte budget of all tests
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clock);
        $display("Watchdog expired in test %s, the run did not finish", test_name);
        $display("Errors found");
        $finish;
    end

endmodule
